// File: bus_pkg.sv
`default_nettype none

package bus_pkg;

  // core side is 32 bits, master port is 64 bits
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;
  localparam int AXI_DATA_W = 64;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;

  // which core port owns the read in flight
  typedef enum logic [1:0] {
    OWN_NONE = 2'd0,
    OWN_IFU  = 2'd1,
    OWN_LSU  = 2'd2
  } owner_e;

  // decoded destination of an address
  typedef enum logic [1:0] {
    TGT_MEM    = 2'd0,
    TGT_CLINT  = 2'd1,
    TGT_SERIAL = 2'd2
  } target_e;

  // axi arsize / awsize codes
  typedef enum logic [2:0] {
    SZ_BYTE = 3'd0,
    SZ_HALF = 3'd1,
    SZ_WORD = 3'd2
  } axi_size_e;

  // core read request, held as a level until rvalid
  typedef struct packed {
    logic valid;
    addr_t addr;
    logic [7:0] rstrb;
  } rd_req_t;

  // lsu store request, held until wready
  typedef struct packed {
    logic valid;
    addr_t addr;
    word_t data;
    logic [3:0] strb;
  } wr_req_t;

  typedef struct packed {
    logic valid;
    addr_t addr;
    axi_size_e size;
  } axi_ar_t;

  typedef struct packed {
    logic valid;
    addr_t addr;
    axi_size_e size;
  } axi_aw_t;

  typedef struct packed {
    logic valid;
    logic last;
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
  } axi_w_t;

  // r beat as seen from the slave
  typedef struct packed {
    logic valid;
    logic [AXI_DATA_W-1:0] data;
    logic [1:0] resp;
  } axi_r_t;

  // latched read handed from select to route and align
  typedef struct packed {
    logic valid;
    addr_t addr;
    logic [7:0] rstrb;
    owner_e owner;
  } sel_rd_t;

endpackage

`default_nettype wire

// File: mmio_pkg.sv
`default_nettype none

package mmio_pkg;

  // store-only byte port, reads here fall through to memory
  localparam bus_pkg::addr_t SERIAL_ADDR = 32'h1000_0000;

  // clint mtime, two 32-bit words
  // low word first, high word 4 bytes above
  localparam bus_pkg::addr_t MTIME_LO_ADDR = 32'h0200_BFF8;
  localparam bus_pkg::addr_t MTIME_HI_ADDR = 32'h0200_BFFC;

endpackage

`default_nettype wire

// File: bus_req_select.sv
`timescale 1ns/1ps
`default_nettype none

module bus_req_select (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire bus_pkg::rd_req_t ifu_req_i,
  input  wire bus_pkg::rd_req_t lsu_req_i,
  input  wire logic             done_i,
  output bus_pkg::sel_rd_t      sel_o
);
  import bus_pkg::*;

  owner_e owner_q;
  owner_e grant_own;
  addr_t addr_q;
  logic [7:0] rstrb_q;
  logic take;

  // lsu wins over ifu when both are up
  always_comb
  begin
    grant_own = OWN_NONE;
    if (lsu_req_i.valid)
      grant_own = OWN_LSU;
    else if (ifu_req_i.valid)
      grant_own = OWN_IFU;
  end

  // only pick a new read when nothing is in flight
  assign take = (owner_q == OWN_NONE) && (grant_own != OWN_NONE);

  always_ff @(posedge clk)
  begin
    if (rst)
      owner_q <= OWN_NONE;
    else if (done_i)
      owner_q <= OWN_NONE;
    else if (take)
      owner_q <= grant_own;
  end

  // request payload kept until the owner is released
  always_ff @(posedge clk)
  begin
    if (take)
    begin
      if (grant_own == OWN_LSU)
      begin
        addr_q  <= lsu_req_i.addr;
        rstrb_q <= lsu_req_i.rstrb;
      end
      else
      begin
        addr_q  <= ifu_req_i.addr;
        rstrb_q <= ifu_req_i.rstrb;
      end
    end
  end

  // in flight from the cycle after the latch
  assign sel_o.valid = (owner_q != OWN_NONE);
  assign sel_o.addr  = addr_q;
  assign sel_o.rstrb = rstrb_q;
  assign sel_o.owner = owner_q;

  // owning port keeps its request level and address until its response
  a_owner_hold: assert property (@(posedge clk) disable iff (rst)
    sel_o.valid |->
      ((sel_o.owner == OWN_LSU) ? (lsu_req_i.valid && (lsu_req_i.addr == addr_q))
                                : (ifu_req_i.valid && (ifu_req_i.addr == addr_q))));

endmodule

`default_nettype wire

// File: bus_addr_route.sv
`timescale 1ns/1ps
`default_nettype none

module bus_addr_route (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire bus_pkg::sel_rd_t sel_i,
  input  wire bus_pkg::wr_req_t wr_req_i,
  output bus_pkg::axi_ar_t      m_ar_o,
  input  wire logic             m_arready_i,
  output bus_pkg::axi_aw_t      m_aw_o,
  input  wire logic             m_awready_i,
  output bus_pkg::axi_w_t       m_w_o,
  input  wire logic             m_wready_i,
  input  wire logic             m_bvalid_i,
  input  wire logic [1:0]       m_bresp_i,
  output logic                  clint_rd_o,
  output logic                  clint_hi_o,
  output logic                  serial_wr_o,
  output logic [7:0]            serial_byte_o,
  output logic                  wready_o,
  output bus_pkg::target_e      rd_target_o
);
  import bus_pkg::*;
  import mmio_pkg::*;

  // r and b are always accepted, rready and bready sit high at the port

  function automatic target_e decode(input addr_t addr);
    target_e tgt;
    tgt = TGT_MEM;
    if (addr == SERIAL_ADDR)
      tgt = TGT_SERIAL;
    else if ((addr == MTIME_LO_ADDR) || (addr == MTIME_HI_ADDR))
      tgt = TGT_CLINT;
    return tgt;
  endfunction

  // 1 -> byte, 3 -> half, f -> word
  function automatic axi_size_e size_of(input logic [7:0] strb);
    axi_size_e sz;
    case (strb)
      8'h01:   sz = SZ_BYTE;
      8'h03:   sz = SZ_HALF;
      default: sz = SZ_WORD;
    endcase
    return sz;
  endfunction

  logic ar_done_q;
  logic clint_done_q;
  logic aw_done_q;
  logic w_done_q;
  logic serial_ack_q;
  logic wr_serial;
  logic mem_wr;
  logic mem_wr_done;

  // reads: clint or memory, a serial read goes to memory
  assign rd_target_o = (decode(sel_i.addr) == TGT_CLINT) ? TGT_CLINT : TGT_MEM;

  assign m_ar_o.valid = sel_i.valid && (rd_target_o == TGT_MEM) && !ar_done_q;
  assign m_ar_o.addr  = sel_i.addr;
  assign m_ar_o.size  = size_of(sel_i.rstrb);

  // one-cycle clint strobe per read
  assign clint_rd_o = sel_i.valid && (rd_target_o == TGT_CLINT) && !clint_done_q;
  assign clint_hi_o = (sel_i.addr == MTIME_HI_ADDR);

  // stores never reach the clint
  assign wr_serial = (decode(wr_req_i.addr) == TGT_SERIAL);
  assign mem_wr    = wr_req_i.valid && !wr_serial;

  // serial store fires once, ack follows a cycle later
  assign serial_wr_o   = wr_req_i.valid && wr_serial && !serial_ack_q;
  assign serial_byte_o = wr_req_i.data[7:0];

  // aw and w go out together, each drops once taken
  assign m_aw_o.valid = mem_wr && !aw_done_q;
  assign m_aw_o.addr  = wr_req_i.addr;
  assign m_aw_o.size  = size_of({4'h0, wr_req_i.strb});

  assign m_w_o.valid = mem_wr && !w_done_q;
  assign m_w_o.last  = m_w_o.valid;
  assign m_w_o.data  = {wr_req_i.data, wr_req_i.data};
  // strobe on the upper lane for addr[2]
  assign m_w_o.strb  = wr_req_i.addr[2] ? {wr_req_i.strb, 4'h0} : {4'h0, wr_req_i.strb};

  // store done in the cycle the later of aw/w lands
  assign mem_wr_done = mem_wr
                    && (aw_done_q || m_awready_i)
                    && (w_done_q || m_wready_i);

  assign wready_o = serial_ack_q || mem_wr_done;

  // read-side flags live as long as the item is in flight
  always_ff @(posedge clk)
  begin
    if (rst || !sel_i.valid)
    begin
      ar_done_q    <= 1'b0;
      clint_done_q <= 1'b0;
    end
    else
    begin
      if (m_ar_o.valid && m_arready_i)
        ar_done_q <= 1'b1;
      if (clint_rd_o)
        clint_done_q <= 1'b1;
    end
  end

  // write-side flags clear with the store
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      aw_done_q    <= 1'b0;
      w_done_q     <= 1'b0;
      serial_ack_q <= 1'b0;
    end
    else
    begin
      serial_ack_q <= serial_wr_o;
      if (mem_wr_done)
      begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
      end
      else
      begin
        if (m_aw_o.valid && m_awready_i)
          aw_done_q <= 1'b1;
        if (m_w_o.valid && m_wready_i)
          w_done_q <= 1'b1;
      end
    end
  end

  // slave must not report a write error
  a_bresp_okay: assert property (@(posedge clk) disable iff (rst)
    m_bvalid_i |-> (m_bresp_i == 2'b00));

endmodule

`default_nettype wire

// File: bus_rdata_align.sv
`timescale 1ns/1ps
`default_nettype none

module bus_rdata_align (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire bus_pkg::sel_rd_t sel_i,
  input  wire bus_pkg::target_e rd_target_i,
  input  wire bus_pkg::axi_r_t  m_r_i,
  input  wire bus_pkg::word_t   clint_rdata_i,
  input  wire logic             clint_rvalid_i,
  output bus_pkg::word_t        ifu_rdata_o,
  output logic                  ifu_rvalid_o,
  output bus_pkg::word_t        lsu_rdata_o,
  output logic                  lsu_rvalid_o,
  output logic                  done_o
);
  import bus_pkg::*;

  word_t lane;
  word_t shifted;
  word_t resp_data;
  logic resp_hit;
  word_t rdata_q;
  logic ifu_rvalid_q;
  logic lsu_rvalid_q;

  // upper half for addr[2]
  assign lane = sel_i.addr[2] ? m_r_i.data[63:32] : m_r_i.data[31:0];

  // byte offset shift, zero fill from the top
  assign shifted = lane >> {sel_i.addr[1:0], 3'b000};

  // clint words are aligned, no shift
  assign resp_data = (rd_target_i == TGT_CLINT) ? clint_rdata_i : shifted;

  // response for the item currently held by select
  always_comb
  begin
    resp_hit = 1'b0;
    if (sel_i.valid)
    begin
      if (rd_target_i == TGT_CLINT)
        resp_hit = clint_rvalid_i;
      else
        resp_hit = m_r_i.valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (resp_hit)
      rdata_q <= resp_data;
  end

  // one-cycle pulse to whoever owns the read
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ifu_rvalid_q <= 1'b0;
      lsu_rvalid_q <= 1'b0;
    end
    else
    begin
      ifu_rvalid_q <= resp_hit && (sel_i.owner == OWN_IFU);
      lsu_rvalid_q <= resp_hit && (sel_i.owner == OWN_LSU);
    end
  end

  assign ifu_rdata_o  = rdata_q;
  assign ifu_rvalid_o = ifu_rvalid_q;
  assign lsu_rdata_o  = rdata_q;
  assign lsu_rvalid_o = lsu_rvalid_q;

  // releases the owner in select
  assign done_o = ifu_rvalid_q || lsu_rvalid_q;

  // slave must not report a read error
  a_rresp_okay: assert property (@(posedge clk) disable iff (rst)
    m_r_i.valid |-> (m_r_i.resp == 2'b00));

endmodule

`default_nettype wire

// File: clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire logic      rd_i,
  input  wire logic      hi_i,
  output bus_pkg::word_t rdata_o,
  output logic           rvalid_o
);
  import bus_pkg::*;

  logic [63:0] mtime_q;
  word_t rdata_q;
  logic rvalid_q;

  // free-running, starts at zero out of reset
  always_ff @(posedge clk)
  begin
    if (rst)
      mtime_q <= 64'd0;
    else
      mtime_q <= mtime_q + 64'd1;
  end

  // pick the requested half
  always_ff @(posedge clk)
  begin
    if (rd_i)
      rdata_q <= hi_i ? mtime_q[63:32] : mtime_q[31:0];
  end

  // response lands one cycle after the strobe
  always_ff @(posedge clk)
  begin
    if (rst)
      rvalid_q <= 1'b0;
    else
      rvalid_q <= rd_i;
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

endmodule

`default_nettype wire

// File: serial_tx_reg.sv
`timescale 1ns/1ps
`default_nettype none

module serial_tx_reg (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       wr_i,
  input  wire logic [7:0] byte_i,
  output logic [7:0]      uart_data_o,
  output logic            uart_valid_o
);

  logic [7:0] data_q;
  logic valid_q;

  // byte held until the next store
  always_ff @(posedge clk)
  begin
    if (wr_i)
      data_q <= byte_i;
  end

  // single-cycle strobe per store
  always_ff @(posedge clk)
  begin
    if (rst)
      valid_q <= 1'b0;
    else
      valid_q <= wr_i;
  end

  assign uart_data_o  = data_q;
  assign uart_valid_o = valid_q;

endmodule

`default_nettype wire

// File: bus_arbiter_top.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter_top (
  input  wire logic             clk,
  input  wire logic             rst,
  // ifu fetch
  input  wire bus_pkg::rd_req_t ifu_req_i,
  output bus_pkg::word_t        ifu_rdata_o,
  output logic                  ifu_rvalid_o,
  // lsu load
  input  wire bus_pkg::rd_req_t lsu_rd_req_i,
  output bus_pkg::word_t        lsu_rdata_o,
  output logic                  lsu_rvalid_o,
  // lsu store
  input  wire bus_pkg::wr_req_t lsu_wr_req_i,
  output logic                  lsu_wready_o,
  // axi master
  output bus_pkg::axi_ar_t      m_ar_o,
  input  wire logic             m_arready_i,
  input  wire bus_pkg::axi_r_t  m_r_i,
  output bus_pkg::axi_aw_t      m_aw_o,
  input  wire logic             m_awready_i,
  output bus_pkg::axi_w_t       m_w_o,
  input  wire logic             m_wready_i,
  input  wire logic             m_bvalid_i,
  input  wire logic [1:0]       m_bresp_i,
  // serial byte out
  output logic [7:0]            uart_data_o,
  output logic                  uart_valid_o
);
  import bus_pkg::*;

  sel_rd_t sel;
  target_e rd_target;
  logic done;
  logic clint_rd;
  logic clint_hi;
  word_t clint_rdata;
  logic clint_rvalid;
  logic serial_wr;
  logic [7:0] serial_byte;

  // stage 1, read arbitration
  bus_req_select u_select (
    .clk       (clk),
    .rst       (rst),
    .ifu_req_i (ifu_req_i),
    .lsu_req_i (lsu_rd_req_i),
    .done_i    (done),
    .sel_o     (sel)
  );

  // stage 2, decode and master channels
  bus_addr_route u_route (
    .clk           (clk),
    .rst           (rst),
    .sel_i         (sel),
    .wr_req_i      (lsu_wr_req_i),
    .m_ar_o        (m_ar_o),
    .m_arready_i   (m_arready_i),
    .m_aw_o        (m_aw_o),
    .m_awready_i   (m_awready_i),
    .m_w_o         (m_w_o),
    .m_wready_i    (m_wready_i),
    .m_bvalid_i    (m_bvalid_i),
    .m_bresp_i     (m_bresp_i),
    .clint_rd_o    (clint_rd),
    .clint_hi_o    (clint_hi),
    .serial_wr_o   (serial_wr),
    .serial_byte_o (serial_byte),
    .wready_o      (lsu_wready_o),
    .rd_target_o   (rd_target)
  );

  // stage 3, lane pick and response
  bus_rdata_align u_align (
    .clk            (clk),
    .rst            (rst),
    .sel_i          (sel),
    .rd_target_i    (rd_target),
    .m_r_i          (m_r_i),
    .clint_rdata_i  (clint_rdata),
    .clint_rvalid_i (clint_rvalid),
    .ifu_rdata_o    (ifu_rdata_o),
    .ifu_rvalid_o   (ifu_rvalid_o),
    .lsu_rdata_o    (lsu_rdata_o),
    .lsu_rvalid_o   (lsu_rvalid_o),
    .done_o         (done)
  );

  clint_timer u_clint (
    .clk      (clk),
    .rst      (rst),
    .rd_i     (clint_rd),
    .hi_i     (clint_hi),
    .rdata_o  (clint_rdata),
    .rvalid_o (clint_rvalid)
  );

  serial_tx_reg u_serial (
    .clk          (clk),
    .rst          (rst),
    .wr_i         (serial_wr),
    .byte_i       (serial_byte),
    .uart_data_o  (uart_data_o),
    .uart_valid_o (uart_valid_o)
  );

endmodule

`default_nettype wire

// File: tb_axi_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire bus_pkg::axi_ar_t ar_i,
  output logic                  arready_o,
  output bus_pkg::axi_r_t       r_o,
  input  wire bus_pkg::axi_aw_t aw_i,
  output logic                  awready_o,
  input  wire bus_pkg::axi_w_t  w_i,
  output logic                  wready_o,
  output logic                  bvalid_o,
  output logic [1:0]            bresp_o
);
  import bus_pkg::*;

  logic [31:0] rng;
  logic rd_pend;
  logic [1:0] rd_wait;
  addr_t rd_addr;
  logic aw_got;
  logic w_got;

  // xorshift32 step
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // beat from the 8-byte-aligned address, upper word xor-marked
  function automatic logic [63:0] beat_of(input addr_t addr);
    addr_t base;
    base = {addr[31:3], 3'b000};
    return {base ^ 32'hA5A5_0000, base};
  endfunction

  initial
  begin
    rng       = 32'd98700;
    rd_pend   = 1'b0;
    rd_wait   = 2'd0;
    rd_addr   = '0;
    aw_got    = 1'b0;
    w_got     = 1'b0;
    arready_o = 1'b0;
    r_o       = '0;
    awready_o = 1'b0;
    wready_o  = 1'b0;
    bvalid_o  = 1'b0;
    bresp_o   = 2'b00;
  end

  // sample handshakes at the edge, drive 1 ns later
  always @(posedge clk)
  begin : slave_step
    logic rst_s;
    logic ar_fire;
    logic aw_fire;
    logic w_fire;
    addr_t ar_addr_s;
    rst_s     = rst;
    ar_fire   = ar_i.valid && arready_o;
    aw_fire   = aw_i.valid && awready_o;
    w_fire    = w_i.valid && wready_o;
    ar_addr_s = ar_i.addr;
    #1;
    rng      = xorshift(rng);
    r_o      = '0;
    bvalid_o = 1'b0;
    if (rst_s)
    begin
      rd_pend = 1'b0;
      aw_got  = 1'b0;
      w_got   = 1'b0;
    end
    else
    begin
      // read beat after 0 to 3 idle cycles
      if (ar_fire)
      begin
        rd_pend = 1'b1;
        rd_addr = ar_addr_s;
        rd_wait = rng[9:8];
      end
      else if (rd_pend)
      begin
        if (rd_wait == 2'd0)
        begin
          r_o.valid = 1'b1;
          r_o.data  = beat_of(rd_addr);
          r_o.resp  = 2'b00;
          rd_pend   = 1'b0;
        end
        else
          rd_wait = rd_wait - 2'd1;
      end
      if (aw_fire)
        aw_got = 1'b1;
      if (w_fire)
        w_got = 1'b1;
      // okay response once both halves of the store are in
      if (aw_got && w_got)
      begin
        bvalid_o = 1'b1;
        aw_got   = 1'b0;
        w_got    = 1'b0;
      end
    end
    // readies about 3 cycles in 4
    arready_o = !rst_s && !rd_pend && (rng[1:0] != 2'b00);
    awready_o = !rst_s && !aw_got && (rng[3:2] != 2'b00);
    wready_o  = !rst_s && !w_got && (rng[5:4] != 2'b00);
  end

endmodule

`default_nettype wire

// File: tb_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bus_arbiter;
  import bus_pkg::*;
  import mmio_pkg::*;

  localparam int N_TESTS = 6;
  localparam int CYCLE_LIMIT = N_TESTS * 200;

  logic clk;
  logic rst;
  rd_req_t ifu_req;
  rd_req_t lsu_rd_req;
  wr_req_t lsu_wr_req;
  word_t ifu_rdata;
  logic ifu_rvalid;
  word_t lsu_rdata;
  logic lsu_rvalid;
  logic lsu_wready;
  axi_ar_t m_ar;
  logic m_arready;
  axi_r_t m_r;
  axi_aw_t m_aw;
  logic m_awready;
  axi_w_t m_w;
  logic m_wready;
  logic m_bvalid;
  logic [1:0] m_bresp;
  logic [7:0] uart_data;
  logic uart_valid;

  // expected values set by the stimulus before each request
  word_t exp_ifu_data;
  word_t exp_lsu_data;
  axi_size_e exp_ar_size;
  addr_t exp_aw_addr;
  axi_size_e exp_aw_size;
  logic [7:0] exp_wstrb;
  word_t exp_wdata;
  logic [7:0] exp_uart;
  word_t first_lo;
  word_t last_lsu;
  // which checks are live
  logic chk_exact;
  logic chk_gt;
  logic order_chk;
  logic lsu_got;
  logic clint_phase;
  logic store_phase;
  logic serial_phase;
  logic aw_seen;
  logic w_seen;
  int err_cnt;
  int err_mark;
  int fail_tests;
  int test_num;
  int cycles;

  bus_arbiter_top dut0 (
    .clk          (clk),
    .rst          (rst),
    .ifu_req_i    (ifu_req),
    .ifu_rdata_o  (ifu_rdata),
    .ifu_rvalid_o (ifu_rvalid),
    .lsu_rd_req_i (lsu_rd_req),
    .lsu_rdata_o  (lsu_rdata),
    .lsu_rvalid_o (lsu_rvalid),
    .lsu_wr_req_i (lsu_wr_req),
    .lsu_wready_o (lsu_wready),
    .m_ar_o       (m_ar),
    .m_arready_i  (m_arready),
    .m_r_i        (m_r),
    .m_aw_o       (m_aw),
    .m_awready_i  (m_awready),
    .m_w_o        (m_w),
    .m_wready_i   (m_wready),
    .m_bvalid_i   (m_bvalid),
    .m_bresp_i    (m_bresp),
    .uart_data_o  (uart_data),
    .uart_valid_o (uart_valid)
  );

  tb_axi_mem u_mem (
    .clk       (clk),
    .rst       (rst),
    .ar_i      (m_ar),
    .arready_o (m_arready),
    .r_o       (m_r),
    .aw_i      (m_aw),
    .awready_o (m_awready),
    .w_i       (m_w),
    .wready_o  (m_wready),
    .bvalid_o  (m_bvalid),
    .bresp_o   (m_bresp)
  );

  initial
    clk = 1'b0;
  always #4 clk = ~clk;

  // word a 32-bit read at addr sees before the byte shift
  function automatic word_t pattern_word(input addr_t addr);
    addr_t base;
    base = {addr[31:3], 3'b000};
    return addr[2] ? (base ^ 32'hA5A5_0000) : base;
  endfunction

  function automatic axi_size_e size_for_strb(input logic [3:0] strb);
    if (strb == 4'h1)
      return SZ_BYTE;
    else if (strb == 4'h3)
      return SZ_HALF;
    return SZ_WORD;
  endfunction

  // handshakes already taken by the store in progress
  always @(posedge clk)
  begin
    if (rst || lsu_wready)
    begin
      aw_seen <= 1'b0;
      w_seen  <= 1'b0;
    end
    else
    begin
      if (m_aw.valid && m_awready)
        aw_seen <= 1'b1;
      if (m_w.valid && m_wready)
        w_seen <= 1'b1;
    end
  end

  // quiet outputs once reset drops
  a_reset_quiet: assert property (@(posedge clk) $fell(rst) |->
    (!m_ar.valid && !m_aw.valid && !m_w.valid && !ifu_rvalid && !lsu_rvalid
     && !lsu_wready && !uart_valid && (dut0.u_select.sel_o.owner == OWN_NONE)))
    else
    begin
      $display("an output or the read owner was active right after reset");
      err_cnt++;
    end

  a_ifu_data: assert property (@(posedge clk) disable iff (rst)
    ifu_rvalid |-> (ifu_rdata == exp_ifu_data))
    else
    begin
      $display("FAIL ifu_rdata_o got %h exp %h", $sampled(ifu_rdata), exp_ifu_data);
      err_cnt++;
    end

  a_lsu_data: assert property (@(posedge clk) disable iff (rst)
    (lsu_rvalid && chk_exact) |-> (lsu_rdata == exp_lsu_data))
    else
    begin
      $display("FAIL lsu_rdata_o got %h exp %h", $sampled(lsu_rdata), exp_lsu_data);
      err_cnt++;
    end

  // mtime must have moved on between two low-word reads
  a_mtime_grows: assert property (@(posedge clk) disable iff (rst)
    (lsu_rvalid && chk_gt) |-> (lsu_rdata > first_lo))
    else
    begin
      $display("FAIL lsu_rdata_o got %h, not above earlier mtime %h",
               $sampled(lsu_rdata), first_lo);
      err_cnt++;
    end

  a_ar_size: assert property (@(posedge clk) disable iff (rst)
    m_ar.valid |-> (m_ar.size == exp_ar_size))
    else
    begin
      $display("FAIL m_ar_o.size got %h exp %h", $sampled(m_ar.size), exp_ar_size);
      err_cnt++;
    end

  a_one_owner: assert property (@(posedge clk) disable iff (rst)
    !(ifu_rvalid && lsu_rvalid))
    else
    begin
      $display("ifu and lsu responses pulsed in the same cycle");
      err_cnt++;
    end

  a_lsu_first: assert property (@(posedge clk) disable iff (rst)
    (order_chk && ifu_rvalid) |-> lsu_got)
    else
    begin
      $display("ifu response arrived while the lsu still owned the read");
      err_cnt++;
    end

  a_clint_no_ar: assert property (@(posedge clk) disable iff (rst)
    clint_phase |-> !m_ar.valid)
    else
    begin
      $display("AR channel went valid during a clint read");
      err_cnt++;
    end

  // latch edge is the first edge that sees the request up
  a_clint_latency: assert property (@(posedge clk) disable iff (rst)
    (clint_phase && lsu_rvalid) |->
      ($past(lsu_rd_req.valid, 3) && !$past(lsu_rd_req.valid, 4)))
    else
    begin
      $display("clint response did not come 3 cycles after the request latch");
      err_cnt++;
    end

  a_aw_addr: assert property (@(posedge clk) disable iff (rst)
    m_aw.valid |-> (m_aw.addr == exp_aw_addr))
    else
    begin
      $display("FAIL m_aw_o.addr got %h exp %h", $sampled(m_aw.addr), exp_aw_addr);
      err_cnt++;
    end

  a_aw_size: assert property (@(posedge clk) disable iff (rst)
    m_aw.valid |-> (m_aw.size == exp_aw_size))
    else
    begin
      $display("FAIL m_aw_o.size got %h exp %h", $sampled(m_aw.size), exp_aw_size);
      err_cnt++;
    end

  a_w_strb: assert property (@(posedge clk) disable iff (rst)
    m_w.valid |-> (m_w.strb == exp_wstrb))
    else
    begin
      $display("FAIL m_w_o.strb got %h exp %h", $sampled(m_w.strb), exp_wstrb);
      err_cnt++;
    end

  a_w_data: assert property (@(posedge clk) disable iff (rst)
    m_w.valid |-> (m_w.data == {exp_wdata, exp_wdata}))
    else
    begin
      $display("FAIL m_w_o.data got %h exp %h", $sampled(m_w.data), {exp_wdata, exp_wdata});
      err_cnt++;
    end

  // single-beat writes, so last follows valid
  a_w_last: assert property (@(posedge clk) disable iff (rst)
    m_w.last == m_w.valid)
    else
    begin
      $display("FAIL m_w_o.last got %h exp %h", $sampled(m_w.last), $sampled(m_w.valid));
      err_cnt++;
    end

  a_wready_late: assert property (@(posedge clk) disable iff (rst)
    (store_phase && lsu_wready) |->
      ((aw_seen || (m_aw.valid && m_awready)) && (w_seen || (m_w.valid && m_wready))))
    else
    begin
      $display("store acknowledged before both AW and W had transferred");
      err_cnt++;
    end

  // back-pressure holds the whole channel
  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    (m_ar.valid && !m_arready) |=> $stable(m_ar))
    else
    begin
      $display("AR channel changed while waiting for arready");
      err_cnt++;
    end

  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    (m_aw.valid && !m_awready) |=> $stable(m_aw))
    else
    begin
      $display("AW channel changed while waiting for awready");
      err_cnt++;
    end

  a_w_hold: assert property (@(posedge clk) disable iff (rst)
    (m_w.valid && !m_wready) |=> $stable(m_w))
    else
    begin
      $display("W channel changed while waiting for wready");
      err_cnt++;
    end

  a_serial_no_aw: assert property (@(posedge clk) disable iff (rst)
    serial_phase |-> (!m_aw.valid && !m_w.valid))
    else
    begin
      $display("serial store leaked onto the AW or W channel");
      err_cnt++;
    end

  a_uart_data: assert property (@(posedge clk) disable iff (rst)
    uart_valid |-> (uart_data == exp_uart))
    else
    begin
      $display("FAIL uart_data_o got %h exp %h", $sampled(uart_data), exp_uart);
      err_cnt++;
    end

  a_uart_with_ack: assert property (@(posedge clk) disable iff (rst)
    (serial_phase && lsu_wready) |-> uart_valid)
    else
    begin
      $display("serial store acknowledged without a uart strobe");
      err_cnt++;
    end

  a_uart_only_serial: assert property (@(posedge clk) disable iff (rst)
    uart_valid |-> serial_phase)
    else
    begin
      $display("uart strobe outside a serial store");
      err_cnt++;
    end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // one fetch with the request dropped right after the pulse
  task automatic fetch(input addr_t addr);
    exp_ifu_data = pattern_word(addr);
    exp_ar_size  = SZ_WORD;
    ifu_req.valid = 1'b1;
    ifu_req.addr  = addr;
    ifu_req.rstrb = 8'h0f;
    do
      @(negedge clk);
    while (!ifu_rvalid);
    next_cycle();
    ifu_req = '0;
    next_cycle();
  endtask

  task automatic load(input addr_t addr, input logic [7:0] strb);
    lsu_rd_req.valid = 1'b1;
    lsu_rd_req.addr  = addr;
    lsu_rd_req.rstrb = strb;
    do
      @(negedge clk);
    while (!lsu_rvalid);
    last_lsu = lsu_rdata;
    next_cycle();
    lsu_rd_req = '0;
    next_cycle();
  endtask

  // memory or serial store held until wready
  task automatic store(input addr_t addr, input word_t data, input logic [3:0] strb);
    exp_aw_addr = addr;
    exp_aw_size = size_for_strb(strb);
    exp_wstrb   = {4'h0, strb} << (4 * addr[2]);
    exp_wdata   = data;
    exp_uart    = data[7:0];
    lsu_wr_req.valid = 1'b1;
    lsu_wr_req.addr  = addr;
    lsu_wr_req.data  = data;
    lsu_wr_req.strb  = strb;
    do
      @(negedge clk);
    while (!lsu_wready);
    next_cycle();
    lsu_wr_req = '0;
    next_cycle();
  endtask

  task automatic end_test(input string name);
    int n;
    n = err_cnt - err_mark;
    test_num++;
    if (n != 0)
      fail_tests++;
    $display("test %0d %s: %s, %0d errors", test_num, name, (n == 0) ? "ok" : "failed", n);
    err_mark = err_cnt;
  endtask

  // run limit
  initial
  begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("STATUS: FAIL");
    $finish;
  end

  initial
  begin
    addr_t a;
    logic [7:0] s;
    int i;
    rst = 1'b1;
    ifu_req = '0;
    lsu_rd_req = '0;
    lsu_wr_req = '0;
    exp_ifu_data = '0;
    exp_lsu_data = '0;
    exp_ar_size = SZ_WORD;
    exp_aw_addr = '0;
    exp_aw_size = SZ_WORD;
    exp_wstrb = '0;
    exp_wdata = '0;
    exp_uart = '0;
    first_lo = '0;
    last_lsu = '0;
    chk_exact = 1'b0;
    chk_gt = 1'b0;
    order_chk = 1'b0;
    lsu_got = 1'b0;
    clint_phase = 1'b0;
    store_phase = 1'b0;
    serial_phase = 1'b0;
    err_cnt = 0;
    err_mark = 0;
    fail_tests = 0;
    test_num = 0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    next_cycle();

    // both lanes of the beat
    fetch(32'h8000_0000);
    fetch(32'h8000_0004);
    fetch(32'h8000_123C);
    end_test("ifu word fetch");

    // bytes then halves at offsets 0..3 on the low lane then the high lane
    chk_exact = 1'b1;
    for (i = 0; i < 16; i++)
    begin
      a = 32'h8000_0120 + 32'(i % 8);
      s = (i >= 8) ? 8'h03 : 8'h01;
      exp_lsu_data = pattern_word(a) >> (8 * a[1:0]);
      exp_ar_size = (s == 8'h01) ? SZ_BYTE : SZ_HALF;
      load(a, s);
    end
    end_test("lsu byte and half loads");

    // same-cycle requests where the lsu has priority
    order_chk = 1'b1;
    lsu_got = 1'b0;
    exp_ar_size = SZ_WORD;
    exp_lsu_data = pattern_word(32'h8000_0308);
    exp_ifu_data = pattern_word(32'h8000_0310);
    lsu_rd_req.valid = 1'b1;
    lsu_rd_req.addr  = 32'h8000_0308;
    lsu_rd_req.rstrb = 8'h0f;
    ifu_req.valid = 1'b1;
    ifu_req.addr  = 32'h8000_0310;
    ifu_req.rstrb = 8'h0f;
    fork
      begin
        do
          @(negedge clk);
        while (!lsu_rvalid);
        lsu_got = 1'b1;
        next_cycle();
        lsu_rd_req = '0;
      end
      begin
        do
          @(negedge clk);
        while (!ifu_rvalid);
        next_cycle();
        ifu_req = '0;
      end
    join
    next_cycle();
    order_chk = 1'b0;
    end_test("lsu over ifu priority");

    // mtime high word still zero while the low word counts
    clint_phase = 1'b1;
    exp_lsu_data = '0;
    load(MTIME_HI_ADDR, 8'h0f);
    chk_exact = 1'b0;
    load(MTIME_LO_ADDR, 8'h0f);
    first_lo = last_lsu;
    chk_gt = 1'b1;
    load(MTIME_LO_ADDR, 8'h0f);
    chk_gt = 1'b0;
    clint_phase = 1'b0;
    end_test("clint mtime reads");

    store_phase = 1'b1;
    store(32'h8000_0400, 32'hDEAD_BEEF, 4'hf);
    store(32'h8000_0404, 32'h0000_C0DE, 4'h3);
    store(32'h8000_040C, 32'h0000_005A, 4'h1);
    store(32'h8000_0408, 32'h1357_9BDF, 4'hf);
    store(32'h8000_0416, 32'h0000_7E57, 4'h3);
    store_phase = 1'b0;
    end_test("memory stores");

    serial_phase = 1'b1;
    store(SERIAL_ADDR, 32'h1234_56C3, 4'h1);
    store(SERIAL_ADDR, 32'h0000_0041, 4'h1);
    serial_phase = 1'b0;
    end_test("serial stores");

    $display("tests %0d, failed %0d, errors %0d", test_num, fail_tests, err_cnt);
    if (err_cnt == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
bus_pkg.sv
mmio_pkg.sv
bus_req_select.sv
bus_addr_route.sv
bus_rdata_align.sv
clint_timer.sv
serial_tx_reg.sv
bus_arbiter_top.sv
tb_axi_mem.sv
tb_bus_arbiter.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the bus bridge testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_bus_arbiter \
  -f src.f \
  -o sim_bus_arbiter

./obj_dir/sim_bus_arbiter | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
